// ==== project.f ====
logic/tia_pkg.sv
logic/beam_timer.sv
logic/player_serializer.sv
logic/pixel_mixer.sv
logic/collision_latch.sv
logic/tia_regs.sv
logic/tia_top.sv
dv/tb_clock.sv
dv/tia_tb.sv

// ==== Bender.yml ====
package:
  name: tia_video

sources:
  - logic/tia_pkg.sv
  - logic/beam_timer.sv
  - logic/player_serializer.sv
  - logic/pixel_mixer.sv
  - logic/collision_latch.sv
  - logic/tia_regs.sv
  - logic/tia_top.sv
  - target: simulation
    files:
      - dv/tb_clock.sv
      - dv/tia_tb.sv

// ==== dv/tia_tb.sv ====
// stops at the first error; model count follows reset and RSYNC, vblank does not blank video
`default_nettype none
`timescale 1ns/1ps

module tia_tb;

  localparam int timeout_cycles = 12 * 228 + 500;  // 12 lines plus slack

  logic       CCLK, rst, sel, we, rdy, hsync, hblank, vsync, vblank;
  logic [5:0] addr;
  logic [7:0] wdata, rdata;
  logic [2:0] lum;
  logic [3:0] col;

  // model state, written on rising edges
  logic [7:0] ref_count, exp_rdata;
  logic       exp_stall, clr_pend, vsync_s, vblank_s, ref0_s, ref1_s;
  logic [2:0] cx_model;   // [2] p0-p1, [1] p0-pf, [0] p1-pf
  logic [7:0] colup0_s, colup1_s, colupf_s, colubk_s, ctrlpf_s;
  logic [7:0] pf0_s, pf1_s, pf2_s, grp0_s, grp1_s, pos0_s, pos1_s;
  logic [31:0] lcg_state = 32'd46;
  int unsigned cycles = 0;

  tb_clock u_clk (.CCLK, .rst);

  tia_top dut (
    .CCLK, .rst, .sel, .we, .addr, .wdata, .rdata, .rdy,
    .hsync, .hblank, .vsync, .vblank, .lum, .col
  );

  function automatic logic [7:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];  // upper bits, best spread
  endfunction

  // playfield pixel 0..19: pf0 4..7, pf1 7..0, pf2 0..7
  function automatic logic pf_bit(input logic [5:0] i);
    if (i < 6'd4) return pf0_s[4 + i];
    if (i < 6'd12) return pf1_s[11 - i];
    return pf2_s[i - 12];
  endfunction

  function automatic logic player_dot(input logic [7:0] px, pos, gfx, input logic refl);
    logic [7:0] k;
    k = px - pos;
    if (px < pos || k > 8'd7) return 1'b0;
    return refl ? gfx[k[2:0]] : gfx[3'd7 - k[2:0]];  // msb leftmost unless reflected
  endfunction

  // {p0, p1, pf} dots at a count, pixel 0 in blank
  function automatic logic [2:0] ref_dots(input logic [7:0] cnt);
    logic [7:0] px;
    logic [5:0] pfx;
    px  = (cnt >= tia_pkg::hblank_end) ? cnt - tia_pkg::hblank_end : 8'd0;
    pfx = px / 4;
    return {player_dot(px, pos0_s, grp0_s, ref0_s), player_dot(px, pos1_s, grp1_s, ref1_s),
            (pfx < 6'd20) ? pf_bit(pfx) : pf_bit(6'd39 - pfx)};
  endfunction

  // {hsync, hblank, lum, col}
  function automatic logic [8:0] ref_video(input logic [7:0] cnt);
    logic [2:0] d;
    logic [7:0] pfc, c;
    logic       vis;
    d   = ref_dots(cnt);
    vis = cnt >= 8'd68;
    pfc = !ctrlpf_s[1] ? colupf_s : (cnt < 8'd148) ? colup0_s : colup1_s;  // score halves
    if (ctrlpf_s[2]) c = d[2] ? colup0_s : d[1] ? colup1_s : d[0] ? pfc : colubk_s;
    else             c = d[0] ? pfc : d[2] ? colup0_s : d[1] ? colup1_s : colubk_s;
    if (!vis) c = 8'h00;
    return {cnt >= 8'd20 && cnt < 8'd36, !vis, c[3:1], c[7:4]};
  endfunction

  always @(posedge CCLK) begin : model_update
    logic [2:0] d;
    logic [7:0] px;
    d  = ref_dots(ref_count);
    px = (ref_count >= tia_pkg::hblank_end) ? ref_count - tia_pkg::hblank_end : 8'd0;
    if (rst) begin
      {ref_count, exp_rdata, exp_stall, clr_pend, cx_model} <= '0;
      {vsync_s, vblank_s, ref0_s, ref1_s, colup0_s, colup1_s, colupf_s} <= '0;
      {colubk_s, ctrlpf_s, pf0_s, pf1_s, pf2_s, grp0_s, grp1_s, pos0_s, pos1_s} <= '0;
    end else begin
      if ((sel && we && addr == tia_pkg::wa_rsync) || ref_count == 8'd227) ref_count <= 8'd0;
      else ref_count <= ref_count + 8'd1;
      if (sel && we && addr == tia_pkg::wa_wsync) exp_stall <= 1'b1;
      else if (ref_count == 8'd0) exp_stall <= 1'b0;  // freed after the line start
      clr_pend <= sel && we && addr == tia_pkg::wa_cxclr;
      if (clr_pend) cx_model <= 3'b000;
      else if (ref_count >= 8'd68) cx_model <= cx_model | {d[2] & d[1], d[2] & d[0], d[1] & d[0]};
      if (sel && we) begin
        case (addr)
          tia_pkg::wa_vsync:  vsync_s  <= wdata[1];
          tia_pkg::wa_vblank: vblank_s <= wdata[1];
          tia_pkg::wa_colup0: colup0_s <= wdata;
          tia_pkg::wa_colup1: colup1_s <= wdata;
          tia_pkg::wa_colupf: colupf_s <= wdata;
          tia_pkg::wa_colubk: colubk_s <= wdata;
          tia_pkg::wa_ctrlpf: ctrlpf_s <= wdata;
          tia_pkg::wa_refp0:  ref0_s   <= wdata[3];
          tia_pkg::wa_refp1:  ref1_s   <= wdata[3];
          tia_pkg::wa_pf0:    pf0_s    <= wdata;
          tia_pkg::wa_pf1:    pf1_s    <= wdata;
          tia_pkg::wa_pf2:    pf2_s    <= wdata;
          tia_pkg::wa_grp0:   grp0_s   <= wdata;
          tia_pkg::wa_grp1:   grp1_s   <= wdata;
          tia_pkg::wa_resp0:  pos0_s   <= (ref_count < 8'd68) ? px + 8'd3 : px;  // late in blank
          tia_pkg::wa_resp1:  pos1_s   <= (ref_count < 8'd68) ? px + 8'd3 : px;
          default: ;
        endcase
      end else if (sel) begin
        case (addr)
          tia_pkg::ra_cxppmm: exp_rdata <= {cx_model[2], 7'b0};
          tia_pkg::ra_cxp0fb: exp_rdata <= {cx_model[1], 7'b0};
          tia_pkg::ra_cxp1fb: exp_rdata <= {cx_model[0], 7'b0};
          default:            exp_rdata <= 8'h00;  // cxm0p and unmapped
        endcase
      end
    end
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [7:0] exp, act);
    stop_with_failure($sformatf("mismatch at %0t ns: %s expected %0h got %0h",
                                $time, name, exp, act));
  endtask

  // outputs still hold pre-edge values here
  always @(posedge CCLK) begin : compare_outputs
    logic [8:0] e;
    e = ref_video(ref_count);
    if (!rst) begin
      assert (hsync === e[8]) else report_mismatch("hsync", e[8], hsync);
      assert (hblank === e[7]) else report_mismatch("hblank", e[7], hblank);
      assert (lum === e[6:4]) else report_mismatch("lum", e[6:4], lum);
      assert (col === e[3:0]) else report_mismatch("col", e[3:0], col);
      assert (rdy === !exp_stall) else report_mismatch("rdy", !exp_stall, rdy);
      assert (vsync === vsync_s) else report_mismatch("vsync", vsync_s, vsync);
      assert (vblank === vblank_s) else report_mismatch("vblank", vblank_s, vblank);
      assert (rdata === exp_rdata) else report_mismatch("rdata", exp_rdata, rdata);
    end
  end

  always @(posedge CCLK) begin : watchdog
    cycles <= cycles + 1;
    if (cycles == timeout_cycles)
      stop_with_failure("timeout: the run went past its cycle limit");
  end

  // one bus cycle from a falling edge, held off while stalled
  task automatic bus_cycle(input logic wr, input logic [5:0] a, input logic [7:0] d);
    while (!rdy) @(negedge CCLK);
    sel   = 1'b1;
    we    = wr;
    addr  = a;
    wdata = d;
    @(negedge CCLK);
    sel = 1'b0;
    we  = 1'b0;
  endtask

  task automatic run_until_count(input logic [7:0] c);
    while (ref_count != c) @(negedge CCLK);
  endtask

  initial begin
    sel = 1'b0; 
    we = 1'b0;
    addr = '0;
    wdata = '0;
    wait (!rst);
    // line timing, three lines after rsync
    bus_cycle(1'b1, tia_pkg::wa_vsync, next_rand() | 8'h02);   // bit 1 forced, vsync goes high
    bus_cycle(1'b1, tia_pkg::wa_vblank, next_rand() | 8'h02);  // same for vblank
    bus_cycle(1'b1, tia_pkg::wa_rsync, 8'h00);
    repeat (3 * 228) @(negedge CCLK);
    // wsync at a random count
    run_until_count(next_rand() % 8'd228);
    bus_cycle(1'b1, tia_pkg::wa_wsync, 8'h00);
    assert (!rdy) else stop_with_failure("rdy stayed high after the WSYNC write");
    while (!rdy) @(negedge CCLK);
    // playfield, normal then score colouring
    bus_cycle(1'b1, tia_pkg::wa_pf0, next_rand());
    bus_cycle(1'b1, tia_pkg::wa_pf1, next_rand());
    bus_cycle(1'b1, tia_pkg::wa_pf2, next_rand());
    bus_cycle(1'b1, tia_pkg::wa_colupf, next_rand());
    bus_cycle(1'b1, tia_pkg::wa_colubk, next_rand());
    bus_cycle(1'b1, tia_pkg::wa_colup0, next_rand());
    bus_cycle(1'b1, tia_pkg::wa_colup1, next_rand());
    repeat (228) @(negedge CCLK);  // any 228 cycles cover every count
    bus_cycle(1'b1, tia_pkg::wa_ctrlpf, 8'h02);
    repeat (228) @(negedge CCLK);
    // players, p0 strobed in blank
    run_until_count(8'd10);
    bus_cycle(1'b1, tia_pkg::wa_resp0, 8'h00);
    run_until_count(8'd100);
    bus_cycle(1'b1, tia_pkg::wa_resp1, 8'h00);
    bus_cycle(1'b1, tia_pkg::wa_grp0, next_rand());
    bus_cycle(1'b1, tia_pkg::wa_grp1, next_rand());
    bus_cycle(1'b1, tia_pkg::wa_refp0, next_rand() | 8'h08);  // p0 reflected
    bus_cycle(1'b1, tia_pkg::wa_refp1, next_rand() & 8'hf7);  // p1 in normal order
    bus_cycle(1'b1, tia_pkg::wa_ctrlpf, 8'h00);
    repeat (228) @(negedge CCLK);
    bus_cycle(1'b1, tia_pkg::wa_ctrlpf, 8'h04);  // players above playfield
    repeat (228) @(negedge CCLK);
    // collisions, all three objects overlap near pixel 4
    bus_cycle(1'b1, tia_pkg::wa_pf0, 8'hff);
    bus_cycle(1'b1, tia_pkg::wa_grp0, 8'hff);
    bus_cycle(1'b1, tia_pkg::wa_grp1, 8'hff);
    run_until_count(8'd72);
    bus_cycle(1'b1, tia_pkg::wa_resp0, 8'h00);
    bus_cycle(1'b1, tia_pkg::wa_resp1, 8'h00);
    repeat (228) @(negedge CCLK);
    assert (cx_model == 3'b111) else stop_with_failure("overlapping objects set no collisions");
    bus_cycle(1'b0, tia_pkg::ra_cxppmm, 8'h00);
    bus_cycle(1'b0, tia_pkg::ra_cxp0fb, 8'h00);
    bus_cycle(1'b0, tia_pkg::ra_cxp1fb, 8'h00);
    bus_cycle(1'b0, tia_pkg::ra_cxm0p, 8'h00);
    bus_cycle(1'b1, tia_pkg::wa_grp0, 8'h00);
    bus_cycle(1'b1, tia_pkg::wa_grp1, 8'h00);
    bus_cycle(1'b1, tia_pkg::wa_cxclr, 8'h00);
    repeat (4) @(negedge CCLK);
    bus_cycle(1'b0, tia_pkg::ra_cxppmm, 8'h00);
    bus_cycle(1'b0, tia_pkg::ra_cxp0fb, 8'h00);
    bus_cycle(1'b0, tia_pkg::ra_cxp1fb, 8'h00);
    bus_cycle(1'b0, 6'h3f, 8'h00);  // unmapped read
    assert (cx_model == 3'b000) else stop_with_failure("collision bits survived CXCLR");
    // p0 over playfield alone, each read then sees its own bit
    bus_cycle(1'b1, tia_pkg::wa_grp0, 8'hff);
    repeat (228) @(negedge CCLK);
    assert (cx_model == 3'b010) else stop_with_failure("p0 over playfield gave other collisions");
    bus_cycle(1'b0, tia_pkg::ra_cxppmm, 8'h00);
    bus_cycle(1'b0, tia_pkg::ra_cxp0fb, 8'h00);
    bus_cycle(1'b0, tia_pkg::ra_cxp1fb, 8'h00);
    @(negedge CCLK);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
// 4 ns CCLK, rst high for the first 8 rising edges, released on a falling edge
`default_nettype none
`timescale 1ns/1ps

module tb_clock (
  output logic CCLK,
  output logic rst
);

  initial begin
    CCLK = 1'b0;
    rst  = 1'b1;
    repeat (8) @(posedge CCLK);
    @(negedge CCLK);
    rst = 1'b0;  // first active edge is 2 ns later
  end

  always #2 CCLK = ~CCLK;

endmodule

`default_nettype wire

// ==== logic/tia_top.sv ====
// single CCLK domain, one bus master; cpu must hold off new accesses while rdy is low
`default_nettype none
`timescale 1ns/1ps

module tia_top (
  input  logic       CCLK,
  input  logic       rst,
  input  logic       sel,
  input  logic       we,
  input  logic [5:0] addr,
  input  logic [7:0] wdata,
  output logic [7:0] rdata,
  output logic       rdy,     // low during wsync stall
  output logic       hsync,
  output logic       hblank,
  output logic       vsync,
  output logic       vblank,
  output logic [2:0] lum,
  output logic [3:0] col
);

  logic               rsync_wr, wsync_wr;
  logic [7:0]         pixel;       // visible pixel, 0 in blank
  logic [5:0]         pf_pixel;
  tia_pkg::bus_data_u colup0, colup1, colupf, colubk, ctrlpf;
  logic               refp0, refp1;
  logic [19:0]        pf;
  logic [7:0]         grp0, grp1, posp0, posp1;
  logic               cx_clear;
  logic [2:0]         cx_bits;     // p0p1, p0pf, p1pf
  logic               dot_p0, dot_p1, dot_pf;

  tia_regs u_regs (
    .CCLK, .rst, .sel, .we, .addr, .wdata, .pixel, .hblank, .cx_bits,
    .rdata, .rsync_wr, .wsync_wr, .vsync, .vblank,
    .colup0, .colup1, .colupf, .colubk, .ctrlpf,
    .refp0, .refp1, .pf, .grp0, .grp1, .posp0, .posp1, .cx_clear
  );

  beam_timer u_beam (
    .CCLK, .rst, .rsync_wr, .wsync_wr, .pixel, .pf_pixel, .hsync, .hblank, .rdy
  );

  player_serializer u_p0 (.pixel, .pos(posp0), .grp(grp0), .reflect(refp0), .dot(dot_p0));
  player_serializer u_p1 (.pixel, .pos(posp1), .grp(grp1), .reflect(refp1), .dot(dot_p1));

  pixel_mixer u_mix (
    .pf_pixel, .hblank, .pf, .ctrlpf, .colup0, .colup1, .colupf, .colubk,
    .dot_p0, .dot_p1, .dot_pf, .lum, .col
  );

  collision_latch u_cx (
    .CCLK, .rst, .cx_clear, .hblank, .dot_p0, .dot_p1, .dot_pf, .cx_bits
  );

endmodule

`default_nettype wire

// ==== logic/tia_regs.sv ====
// writes take effect next cycle, rdata holds until next read, unmapped reads give 0
`default_nettype none
`timescale 1ns/1ps

module tia_regs (
  input  logic               CCLK,
  input  logic               rst,
  input  logic               sel,
  input  logic               we,
  input  logic [5:0]         addr,
  input  logic [7:0]         wdata,
  input  logic [7:0]         pixel,    // current visible pixel for resp strobes
  input  logic               hblank,
  input  logic [2:0]         cx_bits,  // p0p1, p0pf, p1pf
  output logic [7:0]         rdata,
  output logic               rsync_wr,
  output logic               wsync_wr,
  output logic               vsync,
  output logic               vblank,
  output tia_pkg::bus_data_u colup0,
  output tia_pkg::bus_data_u colup1,
  output tia_pkg::bus_data_u colupf,
  output tia_pkg::bus_data_u colubk,
  output tia_pkg::bus_data_u ctrlpf,
  output logic               refp0,
  output logic               refp1,
  output logic [19:0]        pf,
  output logic [7:0]         grp0,
  output logic [7:0]         grp1,
  output logic [7:0]         posp0,
  output logic [7:0]         posp1,
  output logic               cx_clear  // one cycle after cxclr write
);

  tia_pkg::bus_data_u wd;   // write byte, both views
  logic               wr_en;
  logic               rd_en;
  logic [3:0]         pf0_q;  // only upper nibble of pf0 is displayed
  logic [7:0]         pf1_q;
  logic [7:0]         pf2_q;
  logic [7:0]         strobe_pos;

  assign wd    = wdata;
  assign wr_en = sel & we;
  assign rd_en = sel & ~we;

  // strobes straight to the beam timer
  assign rsync_wr = wr_en && (addr == tia_pkg::wa_rsync);
  assign wsync_wr = wr_en && (addr == tia_pkg::wa_wsync);

  assign strobe_pos = hblank ? pixel + tia_pkg::resp_blank_offset : pixel;

  // pf0 7:4 left to right, pf1 reversed, then pf2 lsb first
  assign pf = {pf2_q, {<<{pf1_q}}, pf0_q};

  always_ff @(posedge CCLK) begin
    if (rst) begin
      vsync    <= 1'b0;
      vblank   <= 1'b0;
      colup0   <= '0;
      colup1   <= '0;
      colupf   <= '0;
      colubk   <= '0;
      ctrlpf   <= '0;
      refp0    <= 1'b0;
      refp1    <= 1'b0;
      pf0_q    <= '0;
      pf1_q    <= '0;
      pf2_q    <= '0;
      grp0     <= '0;
      grp1     <= '0;
      posp0    <= '0;
      posp1    <= '0;
      cx_clear <= 1'b0;
    end else begin
      cx_clear <= 1'b0;  // pulse by default
      if (wr_en) begin
        case (addr)
          tia_pkg::wa_vsync:  vsync  <= wd[1];
          tia_pkg::wa_vblank: vblank <= wd[1];  // bits 7:6 ignored, no input ports
          tia_pkg::wa_colup0: colup0 <= wd;
          tia_pkg::wa_colup1: colup1 <= wd;
          tia_pkg::wa_colupf: colupf <= wd;
          tia_pkg::wa_colubk: colubk <= wd;
          tia_pkg::wa_ctrlpf: ctrlpf <= wd;
          tia_pkg::wa_refp0:  refp0  <= wd.ctrl.reflect;
          tia_pkg::wa_refp1:  refp1  <= wd.ctrl.reflect;
          tia_pkg::wa_pf0:    pf0_q  <= wdata[7:4];
          tia_pkg::wa_pf1:    pf1_q  <= wdata;
          tia_pkg::wa_pf2:    pf2_q  <= wdata;
          tia_pkg::wa_resp0:  posp0  <= strobe_pos;
          tia_pkg::wa_resp1:  posp1  <= strobe_pos;
          tia_pkg::wa_grp0:   grp0   <= wdata;  // msb drawn first
          tia_pkg::wa_grp1:   grp1   <= wdata;
          tia_pkg::wa_cxclr:  cx_clear <= 1'b1;
          default: ;  // wsync/rsync decoded above
        endcase
      end
    end
  end

  // collision readback, flags in bit 7
  always_ff @(posedge CCLK) begin
    if (rst) begin
      rdata <= 8'h00;
    end else if (rd_en) begin
      case (addr)
        tia_pkg::ra_cxm0p:  rdata <= 8'h00;  // missile pairs only, none here
        tia_pkg::ra_cxp0fb: rdata <= {cx_bits[1], 7'b0};
        tia_pkg::ra_cxp1fb: rdata <= {cx_bits[0], 7'b0};
        tia_pkg::ra_cxppmm: rdata <= {cx_bits[2], 7'b0};
        default:            rdata <= 8'h00;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/collision_latch.sv ====
// only p0-p1, p0-pf and p1-pf; nothing latches while hblank is high
`default_nettype none
`timescale 1ns/1ps

module collision_latch (
  input  logic       CCLK,
  input  logic       rst,
  input  logic       cx_clear,  // single-cycle pulse
  input  logic       hblank,
  input  logic       dot_p0,
  input  logic       dot_p1,
  input  logic       dot_pf,
  output logic [2:0] cx_bits    // [2] p0p1, [1] p0pf, [0] p1pf
);

  logic [2:0] hits;

  // overlaps this pixel, masked in blank
  assign hits = {dot_p0 & dot_p1, dot_p0 & dot_pf, dot_p1 & dot_pf} & {3{~hblank}};

  always_ff @(posedge CCLK) begin
    if (rst)
      cx_bits <= 3'b000;
    else if (cx_clear)
      cx_bits <= 3'b000;  // clear beats a same-cycle hit
    else
      cx_bits <= cx_bits | hits;  // sticky
  end

endmodule

`default_nettype wire

// ==== logic/pixel_mixer.sv ====
// pf always mirrored on the right half, lum/col forced to 0 in hblank only (not vblank)
`default_nettype none
`timescale 1ns/1ps

module pixel_mixer (
  input  logic [5:0]         pf_pixel,  // 0..39 across the line
  input  logic               hblank,
  input  logic [19:0]        pf,
  input  tia_pkg::bus_data_u ctrlpf,
  input  tia_pkg::bus_data_u colup0,
  input  tia_pkg::bus_data_u colup1,
  input  tia_pkg::bus_data_u colupf,
  input  tia_pkg::bus_data_u colubk,
  input  logic               dot_p0,
  input  logic               dot_p1,
  output logic               dot_pf,
  output logic [2:0]         lum,
  output logic [3:0]         col
);

  // last pf pixel of the line, 39
  localparam logic [5:0] pf_mirror = (tia_pkg::pf_half << 1) - 6'd1;

  logic               left_half;
  logic [4:0]         pf_idx;
  tia_pkg::bus_data_u pf_colour;   // normal or score colour
  tia_pkg::bus_data_u pix_colour;  // winner after priority

  assign left_half = pf_pixel < tia_pkg::pf_half;
  assign pf_idx    = left_half ? pf_pixel[4:0] : 5'(pf_mirror - pf_pixel);  // right half mirrored
  assign dot_pf    = pf[pf_idx];

  // score mode paints each half in its player's colour
  assign pf_colour = ctrlpf.ctrl.score ? (left_half ? colup0 : colup1) : colupf;

  always_comb begin
    if (ctrlpf.ctrl.prio) begin
      if (dot_p0)      pix_colour = colup0;  // players on top
      else if (dot_p1) pix_colour = colup1;
      else if (dot_pf) pix_colour = pf_colour;
      else             pix_colour = colubk;
    end else begin
      if (dot_pf)      pix_colour = pf_colour;  // playfield wins
      else if (dot_p0) pix_colour = colup0;
      else if (dot_p1) pix_colour = colup1;
      else             pix_colour = colubk;
    end
  end

  assign lum = hblank ? 3'd0 : pix_colour.colour.lum;
  assign col = hblank ? 4'd0 : pix_colour.colour.hue;

endmodule

`default_nettype wire

// ==== logic/player_serializer.sv ====
// one 8-pixel copy, no size/copies, no wrap past pixel 159
`default_nettype none
`timescale 1ns/1ps

module player_serializer (
  input  logic [7:0] pixel,    // visible pixel
  input  logic [7:0] pos,      // left edge of the player
  input  logic [7:0] grp,      // graphics, msb leftmost
  input  logic       reflect,  // draw lsb first
  output logic       dot
);

  logic [7:0] offset;   // distance from left edge
  logic       in_span;
  logic [2:0] bit_idx;

  assign offset = pixel - pos;

  // inside the 8 pixels right of pos
  assign in_span = (pixel >= pos) && (offset < 8'd8);

  // normal order msb first
  assign bit_idx = reflect ? offset[2:0] : 3'd7 - offset[2:0];

  assign dot = in_span & grp[bit_idx];

endmodule

`default_nettype wire

// ==== logic/beam_timer.sv ====
// horizontal only, no vertical counting; rsync write restarts the line at count 0
`default_nettype none
`timescale 1ns/1ps

module beam_timer (
  input  logic       CCLK,
  input  logic       rst,
  input  logic       rsync_wr,
  input  logic       wsync_wr,
  output logic [7:0] pixel,     // count - 68, 0 in blank
  output logic [5:0] pf_pixel,  // pixel / 4
  output logic       hsync,
  output logic       hblank,
  output logic       rdy
);

  logic [7:0] count;    // colour clock in line
  logic       stall_q;  // waiting for line start

  always_ff @(posedge CCLK) begin
    if (rst)
      count <= 8'd0;
    else if (rsync_wr)
      count <= 8'd0;
    else if (count == tia_pkg::line_clocks - 8'd1)
      count <= 8'd0;  // wrap 227 -> 0
    else
      count <= count + 8'd1;
  end

  // set wins over release, released after the 0 count
  always_ff @(posedge CCLK) begin
    if (rst)
      stall_q <= 1'b0;
    else if (wsync_wr)
      stall_q <= 1'b1;
    else if (count == 8'd0)
      stall_q <= 1'b0;
  end

  assign rdy    = ~stall_q;
  assign hsync  = (count >= tia_pkg::hsync_start) && (count < tia_pkg::hsync_end);
  assign hblank = count < tia_pkg::hblank_end;
  assign pixel  = hblank ? 8'd0 : count - tia_pkg::hblank_end;
  assign pf_pixel = pixel[7:2];

endmodule

`default_nettype wire

// ==== logic/tia_pkg.sv ====
// ntsc line timing only, 6-bit tia register map without audio/missile/ball/motion regs
`default_nettype none

package tia_pkg;

  // line timing in colour clocks
  localparam logic [7:0] line_clocks = 8'd228;
  localparam logic [7:0] hsync_start = 8'd20;
  localparam logic [7:0] hsync_end   = 8'd36;   // exclusive
  localparam logic [7:0] hblank_end  = 8'd68;   // first visible count
  localparam logic [5:0] pf_half     = 6'd20;   // pf pixels per half line, 4 clocks each

  localparam logic [7:0] resp_blank_offset = 8'd3; // resp strobed in blank lands late

  // write map, original chip numbering
  localparam logic [5:0] wa_vsync  = 6'h00;
  localparam logic [5:0] wa_vblank = 6'h01;
  localparam logic [5:0] wa_wsync  = 6'h02;
  localparam logic [5:0] wa_rsync  = 6'h03;
  localparam logic [5:0] wa_colup0 = 6'h06;
  localparam logic [5:0] wa_colup1 = 6'h07;
  localparam logic [5:0] wa_colupf = 6'h08;
  localparam logic [5:0] wa_colubk = 6'h09;
  localparam logic [5:0] wa_ctrlpf = 6'h0a;
  localparam logic [5:0] wa_refp0  = 6'h0b;
  localparam logic [5:0] wa_refp1  = 6'h0c;
  localparam logic [5:0] wa_pf0    = 6'h0d;
  localparam logic [5:0] wa_pf1    = 6'h0e;
  localparam logic [5:0] wa_pf2    = 6'h0f;
  localparam logic [5:0] wa_resp0  = 6'h10;
  localparam logic [5:0] wa_resp1  = 6'h11;
  localparam logic [5:0] wa_grp0   = 6'h1b;
  localparam logic [5:0] wa_grp1   = 6'h1c;
  localparam logic [5:0] wa_cxclr  = 6'h2c;

  // read map, collision registers only
  localparam logic [5:0] ra_cxm0p  = 6'h00;
  localparam logic [5:0] ra_cxp0fb = 6'h02;
  localparam logic [5:0] ra_cxp1fb = 6'h03;
  localparam logic [5:0] ra_cxppmm = 6'h07;

  // one bus byte, seen as colour/lum or as control flags
  typedef union packed {
    struct packed {
      logic [3:0] hue;      // 7:4
      logic [2:0] lum;      // 3:1
      logic       unused;
    } colour;
    struct packed {
      logic [3:0] rsvd_hi;
      logic       reflect;  // refpx bit 3
      logic       prio;     // ctrlpf bit 2 puts players above pf
      logic       score;    // ctrlpf bit 1
      logic       rsvd_lo;
    } ctrl;
  } bus_data_u;

endpackage

`default_nettype wire
